// ==== rvPkg.sv ====
// shared word, register, control and select types for the rv32i pipeline, imported by the core
package rvPkg;

    typedef logic [31:0] wordT;    // data, address or instruction word
    typedef logic [4:0]  regAddrT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    typedef enum logic [1:0] {
        immI = 2'd0,
        immS = 2'd1,
        immB = 2'd2,
        immJ = 2'd3
    } immSelT;

    // writeback source, same order as the result mux
    typedef enum logic [1:0] {
        resAlu = 2'd0,
        resMem = 2'd1,
        resPc4 = 2'd2
    } resultSelT;

    typedef enum logic [1:0] {
        fwdReg = 2'd0,    // value read in decode
        fwdWb  = 2'd1,
        fwdMem = 2'd2
    } fwdSelT;

    // per-instruction control, all zero acts as a bubble
    typedef struct packed {
        logic      regWrite;
        resultSelT resultSrc;
        logic      memWrite;
        logic      jump;
        logic      branch;
        aluOpT     aluOp;
        logic      aluSrc;    // immediate as operand b
        immSelT    immSel;
    } ctrlT;

endpackage

// ==== instrDecoder.sv ====
// decode stage logic, turns an instruction word into the control struct carried down the pipe
module instrDecoder import rvPkg::*; (
    input  wordT instr,
    output ctrlT ctrl
);

    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regAddrT    rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    always_comb begin
        ctrl = '0;
        case (opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.aluOp = aluAdd;
                    {7'b0100000, 3'b000}: ctrl.aluOp = aluSub;
                    {7'b0000000, 3'b111}: ctrl.aluOp = aluAnd;
                    {7'b0000000, 3'b110}: ctrl.aluOp = aluOr;
                    {7'b0000000, 3'b010}: ctrl.aluOp = aluSlt;
                    default:              ctrl.regWrite = 1'b0;
                endcase
            end
            opImm: if (funct3 == 3'b000) begin    // addi only
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opLoad: if (funct3 == 3'b010) begin   // lw
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resMem;
                ctrl.aluSrc    = 1'b1;
            end
            opStore: if (funct3 == 3'b010) begin  // sw
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSel   = immS;
            end
            opBranch: if (funct3 == 3'b000) begin // beq compares by subtracting
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
                ctrl.immSel = immB;
            end
            opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resPc4;
                ctrl.jump      = 1'b1;
                ctrl.immSel    = immJ;
            end
            default: ;
        endcase
        // a write to x0 is dropped here so no later stage sees it
        if (rd == '0) begin
            ctrl.regWrite = 1'b0;
        end
    end

endmodule

// ==== hazardUnit.sv ====
// hazard logic, picks forwarding sources and raises the load-use stall and branch flush
module hazardUnit import rvPkg::*; (
    input  regAddrT   rs1D,
    input  regAddrT   rs2D,
    input  regAddrT   rs1E,
    input  regAddrT   rs2E,
    input  regAddrT   rdE,
    input  regAddrT   rdM,
    input  regAddrT   rdW,
    input  resultSelT resultSrcE,
    input  logic      regWriteM,
    input  logic      regWriteW,
    input  logic      pcSrcE,
    output logic      stallF,
    output logic      stallD,
    output logic      flushD,
    output logic      flushE,
    output fwdSelT    forwardAE,
    output fwdSelT    forwardBE
);

    logic lwStall;

    // memory stage wins over writeback, x0 is never forwarded
    function automatic fwdSelT pickFwd(regAddrT rs, regAddrT rdMem, logic weMem,
                                       regAddrT rdWb, logic weWb);
        if (weMem && rdMem != '0 && rdMem == rs) begin
            return fwdMem;
        end else if (weWb && rdWb != '0 && rdWb == rs) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign forwardAE = pickFwd(rs1E, rdM, regWriteM, rdW, regWriteW);
    assign forwardBE = pickFwd(rs2E, rdM, regWriteM, rdW, regWriteW);

    assign lwStall = (resultSrcE == resMem) && (rdE != '0) && (rdE == rs1D || rdE == rs2D);

    assign stallF = lwStall;
    assign stallD = lwStall;
    assign flushD = pcSrcE;
    assign flushE = lwStall | pcSrcE;  // bubble behind the load or kill the wrong path

endmodule

// ==== regFile.sv ====
// integer register file, two combinational read ports and one write port with same-cycle bypass
module regFile import rvPkg::*; (
    input  logic    clk,
    input  regAddrT addrA,
    input  regAddrT addrB,
    input  regAddrT addrW,
    input  logic    we,
    input  wordT    dataW,
    output wordT    dataA,
    output wordT    dataB
);

    wordT regs [32];  // slot 0 never written

    always_ff @(posedge clk) begin
        if (we && addrW != '0) begin
            regs[addrW] <= dataW;
        end
    end

    // writeback and decode share a cycle, so the new value goes straight through
    assign dataA = (addrA == '0) ? '0 :
                   (we && addrA == addrW) ? dataW : regs[addrA];
    assign dataB = (addrB == '0) ? '0 :
                   (we && addrB == addrW) ? dataW : regs[addrB];

endmodule

// ==== aluExec.sv ====
// execute stage ALU, add/sub/and/or/signed slt with a zero flag for beq
module aluExec import rvPkg::*; (
    input  wordT  srcA,
    input  wordT  srcB,
    input  aluOpT op,
    output wordT  result,
    output logic  zero
);

    always_comb begin
        case (op)
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluSlt:  result = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            default: result = srcA + srcB;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== pipeDatapath.sv ====
// five-stage datapath with PC, pipeline registers, forwarding muxes and writeback select
module pipeDatapath import rvPkg::*; #(
    parameter wordT resetPc = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      arstN,
    input  ctrlT      ctrlD,
    input  logic      stallF,
    input  logic      stallD,
    input  logic      flushD,
    input  logic      flushE,
    input  fwdSelT    forwardAE,
    input  fwdSelT    forwardBE,
    output wordT      pc,
    input  wordT      instr,
    output wordT      instrD,
    output regAddrT   rs1D,
    output regAddrT   rs2D,
    output regAddrT   rs1E,
    output regAddrT   rs2E,
    output regAddrT   rdE,
    output regAddrT   rdM,
    output regAddrT   rdW,
    output resultSelT resultSrcE,
    output logic      regWriteM,
    output logic      regWriteW,
    output logic      pcSrcE,
    output wordT      dataAddr,
    output wordT      dataWrData,
    output logic      dataWe,
    input  wordT      dataRdData,
    output wordT      resultW
);

    typedef struct packed {
        wordT    rd1;
        wordT    rd2;
        wordT    pc;
        wordT    imm;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
    } decExT;

    typedef struct packed {
        wordT    aluResult;
        wordT    data;      // store data in memory, load data in writeback
        wordT    pcPlus4;
        regAddrT rd;
    } stageT;

    ctrlT  ctrlE, ctrlM, ctrlW;
    decExT de;
    stageT em, mw;
    wordT  pcNext, pcD, rd1D, rd2D, immD;
    wordT  srcAE, writeDataE, srcBE, aluResultE, targetE;
    logic  zeroE;

    function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT wbVal, wordT memVal);
        case (sel)
            fwdWb:   return wbVal;
            fwdMem:  return memVal;
            default: return regVal;
        endcase
    endfunction

    // fetch
    assign pcNext = pcSrcE ? targetE : pc + 32'd4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else if (!stallF) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrD <= '0;
        end else if (flushD) begin
            instrD <= '0;    // opcode 0 decodes to a bubble
        end else if (!stallD) begin
            instrD <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD <= pc;
        end
    end

    // decode
    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];

    regFile rf_i (
        .clk   (clk),
        .addrA (rs1D),
        .addrB (rs2D),
        .addrW (rdW),
        .we    (regWriteW),
        .dataW (resultW),
        .dataA (rd1D),
        .dataB (rd2D)
    );

    always_comb begin
        case (ctrlD.immSel)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    // pipeline control, cleared by reset and flush
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlE <= '0;
            ctrlM <= '0;
            ctrlW <= '0;
        end else begin
            ctrlE <= flushE ? '0 : ctrlD;
            ctrlM <= ctrlE;
            ctrlW <= ctrlM;
        end
    end

    always_ff @(posedge clk) begin
        de <= '{rd1D, rd2D, pcD, immD, rs1D, rs2D, instrD[11:7]};
        em <= '{aluResultE, writeDataE, de.pc + 32'd4, de.rd};
        mw <= '{em.aluResult, dataRdData, em.pcPlus4, em.rd};
    end

    // execute
    assign srcAE      = fwdMux(forwardAE, de.rd1, resultW, em.aluResult);
    assign writeDataE = fwdMux(forwardBE, de.rd2, resultW, em.aluResult);
    assign srcBE      = ctrlE.aluSrc ? de.imm : writeDataE;

    aluExec alu_i (
        .srcA   (srcAE),
        .srcB   (srcBE),
        .op     (ctrlE.aluOp),
        .result (aluResultE),
        .zero   (zeroE)
    );

    assign targetE = de.pc + de.imm;
    assign pcSrcE  = ctrlE.jump | (ctrlE.branch & zeroE);

    assign rs1E       = de.rs1;
    assign rs2E       = de.rs2;
    assign rdE        = de.rd;
    assign resultSrcE = ctrlE.resultSrc;

    // memory
    assign dataAddr   = em.aluResult;
    assign dataWrData = em.data;
    assign dataWe     = ctrlM.memWrite;
    assign rdM        = em.rd;
    assign regWriteM  = ctrlM.regWrite;

    // writeback
    always_comb begin
        case (ctrlW.resultSrc)
            resMem:  resultW = mw.data;
            resPc4:  resultW = mw.pcPlus4;
            default: resultW = mw.aluResult;
        endcase
    end

    assign rdW       = mw.rd;
    assign regWriteW = ctrlW.regWrite;

endmodule

// ==== rvCore.sv ====
// top of the pipelined rv32i core, ties decoder, hazard unit and datapath to the memory ports
module rvCore import rvPkg::*; #(
    parameter wordT resetPc = 32'h0000_0000
) (
    input  logic    clk,
    input  logic    arstN,
    output wordT    pc,
    input  wordT    instr,
    output wordT    dataAddr,
    output wordT    dataWrData,
    output logic    dataWe,
    input  wordT    dataRdData,
    output logic    regWriteW,
    output regAddrT rdW,
    output wordT    resultW
);

    wordT      instrD;
    ctrlT      ctrlD;
    regAddrT   rs1D, rs2D, rs1E, rs2E, rdE, rdM;
    resultSelT resultSrcE;
    logic      regWriteM, pcSrcE;
    logic      stallF, stallD, flushD, flushE;
    fwdSelT    forwardAE, forwardBE;

    instrDecoder dec_i (
        .instr (instrD),
        .ctrl  (ctrlD)
    );

    hazardUnit haz_i (
        .rs1D       (rs1D),
        .rs2D       (rs2D),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .rdM        (rdM),
        .rdW        (rdW),
        .resultSrcE (resultSrcE),
        .regWriteM  (regWriteM),
        .regWriteW  (regWriteW),
        .pcSrcE     (pcSrcE),
        .stallF     (stallF),
        .stallD     (stallD),
        .flushD     (flushD),
        .flushE     (flushE),
        .forwardAE  (forwardAE),
        .forwardBE  (forwardBE)
    );

    pipeDatapath #(
        .resetPc (resetPc)
    ) dp_i (
        .clk        (clk),
        .arstN      (arstN),
        .ctrlD      (ctrlD),
        .stallF     (stallF),
        .stallD     (stallD),
        .flushD     (flushD),
        .flushE     (flushE),
        .forwardAE  (forwardAE),
        .forwardBE  (forwardBE),
        .pc         (pc),
        .instr      (instr),
        .instrD     (instrD),
        .rs1D       (rs1D),
        .rs2D       (rs2D),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .rdM        (rdM),
        .rdW        (rdW),
        .resultSrcE (resultSrcE),
        .regWriteM  (regWriteM),
        .regWriteW  (regWriteW),
        .pcSrcE     (pcSrcE),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .dataWe     (dataWe),
        .dataRdData (dataRdData),
        .resultW    (resultW)
    );

endmodule

// ==== rvCore_checker.sv ====
// assertions bound into the datapath, covering reset state, x0 writes and the fetch stall
module rvCore_checker import rvPkg::*; (
    input logic    clk,
    input logic    arstN,
    input logic    regWriteW,
    input regAddrT rdW,
    input logic    dataWe,
    input logic    stallF,
    input wordT    pc
);
    timeunit 1ns;
    timeprecision 1ps;

    noWriteInReset: assert property (@(posedge clk) !arstN |-> !regWriteW)
        else $error("register write requested while in reset");

    noStoreInReset: assert property (@(posedge clk) !arstN |-> !dataWe)
        else $error("data write enable high while in reset");

    noZeroDest: assert property (@(posedge clk) disable iff (!arstN) regWriteW |-> rdW != '0)
        else $error("register write retired with x0 as destination");

    // fetch address frozen for the stalled cycle
    pcHoldsOnStall: assert property (@(posedge clk) disable iff (!arstN) stallF |=> $stable(pc))
        else $error("pc moved while fetch was stalled");

endmodule

bind pipeDatapath rvCore_checker chk_i (
    .clk       (clk),
    .arstN     (arstN),
    .regWriteW (regWriteW),
    .rdW       (rdW),
    .dataWe    (dataWe),
    .stallF    (stallF),
    .pc        (pc)
);

// ==== rvCore_tb.sv ====
// top-level testbench that runs a short program on the rv32i core and checks the retire trace
module rvCore_tb import rvPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int   progLen     = 22;
    localparam int   traceLen    = 15;
    localparam int   cycleLimit  = 4 * progLen + 40;
    localparam int   drainCycles = 8;
    localparam int   retireDelay = 4;   // fetch to writeback with no stall
    localparam int   noStallLen  = 8;   // x1 to x8 retire back to back
    localparam int   opImm       = 'h13;
    localparam int   opLoad      = 'h03;
    localparam wordT nopWord     = 32'h0000_0013;  // addi x0, x0, 0

    typedef struct packed {
        regAddrT rd;
        wordT    value;
    } retireT;

    logic    clk = 1'b0;
    logic    arstN;
    wordT    pc, instr, dataAddr, dataWrData, dataRdData, resultW;
    logic    dataWe, regWriteW;
    regAddrT rdW;

    wordT   prog [progLen];
    retireT trace [traceLen];
    wordT   ram [64];
    int     errors = 0;
    int     cycles = 0;
    int     idx = 0;

    rvCore #(
        .resetPc (32'h0000_0000)
    ) dut_i (
        .clk        (clk),
        .arstN      (arstN),
        .pc         (pc),
        .instr      (instr),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .dataWe     (dataWe),
        .dataRdData (dataRdData),
        .regWriteW  (regWriteW),
        .rdW        (rdW),
        .resultW    (resultW)
    );

    always #4 clk = ~clk;

    // instruction encoders for the rv32i formats
    function automatic wordT rType(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic wordT iType(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic wordT sType(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic wordT bType(int imm, int rs2, int rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic wordT jType(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic wordT fillWord(int index);
        return {16'hC0DE, 10'd0, index[5:0]};
    endfunction

    function automatic wordT fetchWord(wordT addr);
        int index;
        index = int'(addr >> 2);
        if (index < progLen) begin
            return prog[index];
        end
        return nopWord;  // past the end of the program
    endfunction

    // data RAM refilled during reset
    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= fillWord(i);
            end
        end else if (dataWe) begin
            ram[dataAddr[7:2]] <= dataWrData;
        end
    end

    initial begin
        prog[0]  = iType(6, 0, 0, 1, opImm);     // addi x1, x0, 6
        prog[1]  = iType(-3, 0, 0, 2, opImm);    // addi x2, x0, -3
        prog[2]  = rType(0, 0, 3, 1, 2);         // add x3 from wb and mem
        prog[3]  = rType('h20, 0, 4, 1, 2);      // sub x4
        prog[4]  = rType(0, 7, 5, 3, 4);         // and x5
        prog[5]  = rType(0, 6, 6, 3, 4);         // or x6
        prog[6]  = rType(0, 2, 7, 2, 1);         // slt x7 with the negative operand first
        prog[7]  = rType(0, 2, 8, 1, 2);         // slt x8
        prog[8]  = sType(8, 6, 0);               // sw x6, 8(x0)
        prog[9]  = iType(8, 0, 2, 9, opLoad);    // lw x9, 8(x0)
        prog[10] = rType(0, 0, 10, 9, 1);        // load-use
        prog[11] = bType(12, 1, 1);              // beq taken to 14
        prog[12] = iType(100, 0, 0, 11, opImm);
        prog[13] = iType(200, 0, 0, 12, opImm);
        prog[14] = bType(8, 2, 1);               // beq not taken
        prog[15] = iType(7, 0, 0, 13, opImm);
        prog[16] = iType(8, 0, 0, 14, opImm);
        prog[17] = jType(12, 15);                // jal x15 to 20
        prog[18] = iType(1, 0, 0, 16, opImm);
        prog[19] = iType(2, 0, 0, 17, opImm);
        prog[20] = iType(1, 15, 0, 18, opImm);   // addi x18, x15, 1
        prog[21] = iType(40, 0, 2, 19, opLoad);  // lw from the fill pattern

        trace[0]  = '{5'd1,  32'd6};
        trace[1]  = '{5'd2,  32'hFFFF_FFFD};
        trace[2]  = '{5'd3,  32'd3};
        trace[3]  = '{5'd4,  32'd9};
        trace[4]  = '{5'd5,  32'd1};
        trace[5]  = '{5'd6,  32'd11};
        trace[6]  = '{5'd7,  32'd1};
        trace[7]  = '{5'd8,  32'd0};
        trace[8]  = '{5'd9,  32'd11};
        trace[9]  = '{5'd10, 32'd17};
        trace[10] = '{5'd13, 32'd7};
        trace[11] = '{5'd14, 32'd8};
        trace[12] = '{5'd15, 32'd72};
        trace[13] = '{5'd18, 32'd73};
        trace[14] = '{5'd19, 32'hC0DE_000A};
    end

    task automatic driveInputs();
        instr      = fetchWord(pc);
        dataRdData = ram[dataAddr[7:2]];
    endtask

    task automatic checkRetire(retireT expected);
        // the forwarding chain at the start retires one write per cycle
        if (idx < noStallLen) begin
            assert (cycles == retireDelay + idx) else begin
                $display("[FAIL] %0t: cycles at retire of x%0d expected %0d, got %0d",
                         $time, expected.rd, retireDelay + idx, cycles);
                errors++;
            end
        end
        assert (rdW == expected.rd) else begin
            $display("[FAIL] %0t: rdW expected %0d, got %0d", $time, expected.rd, rdW);
            errors++;
        end
        assert (resultW == expected.value) else begin
            $display("[FAIL] %0t: resultW expected 0x%08h, got 0x%08h",
                     $time, expected.value, resultW);
            errors++;
        end
    endtask

    task automatic finishRun();
        $display("register writes checked: %0d of %0d, errors: %0d", idx, traceLen, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        arstN      = 1'b0;
        instr      = nopWord;
        dataRdData = '0;
        repeat (10) begin
            @(negedge clk);
            driveInputs();
        end
        arstN = 1'b1;
        while (idx < traceLen && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
            if (regWriteW && rdW != '0) begin
                checkRetire(trace[idx]);
                idx++;
            end
            driveInputs();
        end
        if (idx < traceLen) begin
            $display("timeout: only %0d of %0d register writes seen in %0d cycles",
                     idx, traceLen, cycles);
            errors++;
        end else begin
            // skipped instructions must not show up late either
            repeat (drainCycles) begin
                @(negedge clk);
                assert (!(regWriteW && rdW != '0)) else begin
                    $display("unexpected register write to x%0d after the trace ended", rdW);
                    errors++;
                end
                driveInputs();
            end
        end
        finishRun();
    end

endmodule

// ==== all.f ====
rvPkg.sv
instrDecoder.sv
hazardUnit.sv
regFile.sv
aluExec.sv
pipeDatapath.sv
rvCore.sv
rvCore_checker.sv
rvCore_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvCore_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
